// ==== test/fp_mul_input.dat ====
# I test op rd rs1 rs2 imm, op 0 li 1 fmul 2 fnmul, all fields hex except test
# E tag data in issue order of the multiplies, R reg data for the final registers
I 1 0 0 0 0 3f800000
I 1 0 1 0 0 40000000
I 1 0 2 0 0 40400000
I 1 0 3 0 0 3fc00000
I 1 0 4 0 0 3f000000
I 2 1 5 1 2 00000000
I 2 1 6 3 3 00000000
I 2 0 7 0 0 7f000000
I 2 1 7 7 1 00000000
I 2 0 0 0 0 3f800001
I 2 1 0 0 0 00000000
I 3 2 5 2 4 00000000
I 3 0 3 0 0 00000000
I 3 2 3 3 1 00000000
I 3 0 2 0 0 00800000
I 3 2 2 2 4 00000000
I 4 1 1 5 1 00000000
I 4 1 4 1 1 00000000
I 4 0 6 0 0 40800000
I 4 1 6 6 6 00000000
I 5 0 0 0 0 3fc00000
I 5 1 1 0 0 00000000
I 5 2 2 0 0 00000000
I 5 1 1 0 0 00000000
I 5 2 2 0 0 00000000
I 5 1 1 0 0 00000000
I 5 2 2 0 0 00000000
I 5 1 1 0 0 00000000
I 5 2 2 0 0 00000000
I 5 1 1 0 0 00000000
I 5 2 2 0 0 00000000
E 0 40c00000
E 1 40100000
E 2 7f7fffff
E 3 3f800002
E 4 bfc00000
E 5 80000000
E 6 80000000
E 7 c0400000
E 0 41100000
E 1 41800000
E 2 40100000
E 3 c0100000
E 4 40100000
E 5 c0100000
E 6 40100000
E 7 c0100000
E 0 40100000
E 1 c0100000
E 2 40100000
E 3 c0100000
R 0 3fc00000
R 1 40100000
R 2 c0100000
R 3 80000000
R 4 41100000
R 5 bfc00000
R 6 41800000
R 7 7f7fffff

// ==== build.f ====
+incdir+common
common/fpu_data_pkg.sv
common/fpu_issue_pkg.sv
common/cdb_if.sv
common/dispatch_if.sv
rtl/fpr_rename.sv
rtl/fmul_station.sv
fmul/fmul_pipe.sv
rtl/fp_mul_cluster.sv
test/fp_mul_checker.sv
test/fp_mul_cluster_tb.sv

// ==== test/fp_mul_cluster_tb.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_mul_cluster_tb;
	logic clk = 1'b0;
	logic reset = 1'b1;
	logic issue_valid = 1'b0;
	logic issue_ready;
	fpu_issue_pkg::opcode_e issue_op = fpu_issue_pkg::op_li;
	logic [`FPU_REG_WIDTH-1:0] issue_rd = '0;
	logic [`FPU_REG_WIDTH-1:0] issue_rs1 = '0;
	logic [`FPU_REG_WIDTH-1:0] issue_rs2 = '0;
	fpu_data_pkg::word_t issue_imm = '0;
	logic [`FPU_TAG_WIDTH-1:0] issue_tag;
	logic cdb_valid;
	logic cdb_ready = 1'b1;
	logic [`FPU_TAG_WIDTH-1:0] cdb_tag;
	fpu_data_pkg::word_t cdb_data;
	logic [`FPU_REG_WIDTH-1:0] reg_addr = '0;
	fpu_data_pkg::word_t reg_data;
	logic reg_busy;

	int n_i = 0;
	int n_e = 0;
	int n_r = 0;
	int i_test [64];
	logic [31:0] i_op [64];
	logic [31:0] i_rd [64];
	logic [31:0] i_rs1 [64];
	logic [31:0] i_rs2 [64];
	logic [31:0] i_imm [64];
	logic [31:0] e_tag [64];
	logic [31:0] e_data [64];
	logic [31:0] r_reg [8];
	logic [31:0] r_data [8];
	string test_names [1:6];
	int cur_test = 0;
	int cycles = 0;
	int limit = 0;
	int mul_count = 0;
	logic [7:0] lfsr = 8'd59;
	logic file_ok;

	always #2 clk = ~clk;

	fp_mul_cluster i_fp_mul_cluster (.*);

	fp_mul_checker i_checker (
		.clk(clk),
		.reset(reset),
		.cdb_valid(cdb_valid),
		.cdb_ready(cdb_ready),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.reg_data(reg_data),
		.reg_busy(reg_busy)
	);

	// Taps 8, 6, 5, 4.
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	always @(posedge clk) begin
		if (cur_test == 5) begin
			lfsr = lfsr_step(lfsr);
			#1;
			cdb_ready = lfsr[0];
		end else begin
			#1;
			cdb_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic read_data_file(output logic ok);
		int fd;
		int rc;
		string line;
		int t;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] f;
		ok = 1'b0;
		fd = $fopen("test/fp_mul_input.dat", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (line.len() == 0) begin
					continue;
				end
				case (line[0])
					"I": begin
						rc = $sscanf(line, "I %d %h %h %h %h %h", t, a, b, c, d, f);
						i_test[n_i] = t;
						i_op[n_i] = a;
						i_rd[n_i] = b;
						i_rs1[n_i] = c;
						i_rs2[n_i] = d;
						i_imm[n_i] = f;
						n_i++;
					end
					"E": begin
						rc = $sscanf(line, "E %h %h", a, b);
						e_tag[n_e] = a;
						e_data[n_e] = b;
						n_e++;
					end
					"R": begin
						rc = $sscanf(line, "R %h %h", a, b);
						r_reg[n_r] = a;
						r_data[n_r] = b;
						n_r++;
					end
					default: ;
				endcase
			end
			$fclose(fd);
		end
	endtask

	task automatic issue_instr(input int k);
		logic accepted;
		accepted = 1'b0;
		issue_valid = 1'b1;
		issue_op = fpu_issue_pkg::opcode_e'(i_op[k][1:0]);
		issue_rd = i_rd[k][2:0];
		issue_rs1 = i_rs1[k][2:0];
		issue_rs2 = i_rs2[k][2:0];
		issue_imm = i_imm[k];
		while (!accepted) begin
			@(negedge clk);
			if (issue_ready) begin
				accepted = 1'b1;
				if (issue_op != fpu_issue_pkg::op_li) begin
					i_checker.check_value("issue tag", e_tag[mul_count], 32'(issue_tag));
					i_checker.expect_result(e_tag[mul_count][2:0], e_data[mul_count]);
					mul_count++;
				end
			end
			@(posedge clk);
			#1;
		end
		issue_valid = 1'b0;
		if (issue_op == fpu_issue_pkg::op_li) begin
			reg_addr = issue_rd;
			@(negedge clk);
			i_checker.check_reg($sformatf("li readback r%0d", issue_rd), issue_imm);
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		test_names[1] = "immediate_load";
		test_names[2] = "multiply_results";
		test_names[3] = "negated_multiply";
		test_names[4] = "dependencies";
		test_names[5] = "back_pressure";
		test_names[6] = "final_state";
		read_data_file(file_ok);
		if (!file_ok) begin
			$display("Cannot open data file test/fp_mul_input.dat");
			$display("TESTS FAILED");
			$finish;
		end else begin
			limit = 64 * (n_i + n_e + n_r);
			repeat (16) @(posedge clk);
			#1;
			reset = 1'b0;
			for (int t = 1; t <= 6; t++) begin
				cur_test = t;
				i_checker.start_test(test_names[t]);
				for (int k = 0; k < n_i; k++) begin
					if (i_test[k] == t) begin
						issue_instr(k);
					end
				end
				while (i_checker.pending() != 0) begin
					@(posedge clk);
					#1;
				end
				repeat (2) @(posedge clk);
				#1;
				if (t == 6) begin
					for (int k = 0; k < n_r; k++) begin
						reg_addr = r_reg[k][2:0];
						@(negedge clk);
						i_checker.check_reg($sformatf("final r%0d", r_reg[k]), r_data[k]);
						@(posedge clk);
						#1;
					end
				end
				i_checker.finish_test();
			end
			$display("%0d tests passed, %0d tests failed, %0d checks failed",
			         i_checker.tests_passed, i_checker.tests_failed, i_checker.total_errors);
			if (i_checker.total_errors == 0 && i_checker.tests_failed == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end
endmodule

// ==== test/fp_mul_checker.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_mul_checker (
	input logic clk,
	input logic reset,
	input logic cdb_valid,
	input logic cdb_ready,
	input logic [`FPU_TAG_WIDTH-1:0] cdb_tag,
	input fpu_data_pkg::word_t cdb_data,
	input fpu_data_pkg::word_t reg_data,
	input logic reg_busy
);
	localparam int NUM_TAGS = 1 << `FPU_TAG_WIDTH;

	string test_name = "none";
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	fpu_data_pkg::word_t exp_data [NUM_TAGS];
	logic [NUM_TAGS-1:0] exp_valid = '0;  // One outstanding result per tag at most.
	logic held = 1'b0;
	logic [`FPU_TAG_WIDTH-1:0] held_tag;
	fpu_data_pkg::word_t held_data;

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic report(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		test_errors++;
		total_errors++;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
			total_errors++;
		end
	endtask

	// The addressed register must hold the value and have no writer pending.
	task automatic check_reg(input string what, input logic [31:0] exp);
		check_value(what, exp, reg_data);
		check_value({what, " busy flag"}, 32'd0, 32'(reg_busy));
	endtask

	task automatic expect_result(input logic [`FPU_TAG_WIDTH-1:0] tag, input logic [31:0] data);
		if (exp_valid[tag]) begin
			report($sformatf("tag %0d was handed out again before its result came back", tag));
		end
		exp_data[tag] = data;
		exp_valid[tag] = 1'b1;
	endtask

	function automatic int pending();
		return $countones(exp_valid);
	endfunction

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("Test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("Test %s: failed with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// A held result must stay put until the cycle it is accepted.
	always @(posedge clk) begin
		if (reset) begin
			held = 1'b0;
		end else begin
			if (held && (!cdb_valid || cdb_tag !== held_tag || cdb_data !== held_data)) begin
				report("CDB result changed or vanished before it was accepted");
			end
			held = cdb_valid && !cdb_ready;
			held_tag = cdb_tag;
			held_data = cdb_data;
			if (cdb_valid && cdb_ready) begin
				if (!exp_valid[cdb_tag]) begin
					report($sformatf("CDB broadcast tag %0d with no result outstanding", cdb_tag));
				end else begin
					check_value($sformatf("result tag %0d", cdb_tag), exp_data[cdb_tag], cdb_data);
					exp_valid[cdb_tag] = 1'b0;
				end
			end
		end
	end
endmodule

// ==== rtl/fp_mul_cluster.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fp_mul_cluster (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input fpu_issue_pkg::opcode_e issue_op,
	input logic [`FPU_REG_WIDTH-1:0] issue_rd,
	input logic [`FPU_REG_WIDTH-1:0] issue_rs1,
	input logic [`FPU_REG_WIDTH-1:0] issue_rs2,
	input fpu_data_pkg::word_t issue_imm,
	output logic [`FPU_TAG_WIDTH-1:0] issue_tag,
	output logic cdb_valid,
	input logic cdb_ready,
	output logic [`FPU_TAG_WIDTH-1:0] cdb_tag,
	output fpu_data_pkg::word_t cdb_data,
	input logic [`FPU_REG_WIDTH-1:0] reg_addr,
	output fpu_data_pkg::word_t reg_data,
	output logic reg_busy
);
	logic rs_valid;
	logic rs_ready;
	fpu_issue_pkg::issue_op_t rs_op;

	cdb_if cdb ();
	dispatch_if disp ();

	assign cdb.ready = cdb_ready;
	assign cdb_valid = cdb.valid;
	assign cdb_tag = cdb.tag;
	assign cdb_data = cdb.data;

	fpr_rename i_fpr_rename (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_op(issue_op),
		.issue_rd(issue_rd),
		.issue_rs1(issue_rs1),
		.issue_rs2(issue_rs2),
		.issue_imm(issue_imm),
		.issue_tag(issue_tag),
		.rs_valid(rs_valid),
		.rs_ready(rs_ready),
		.rs_op(rs_op),
		.cdb(cdb.listener),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_busy(reg_busy)
	);

	fmul_station i_fmul_station (
		.clk(clk),
		.reset(reset),
		.rs_valid(rs_valid),
		.rs_ready(rs_ready),
		.rs_op(rs_op),
		.cdb(cdb.listener),
		.disp(disp.source)
	);

	fmul_pipe i_fmul_pipe (
		.clk(clk),
		.reset(reset),
		.disp(disp.sink),
		.cdb(cdb.producer)
	);
endmodule

// ==== fmul/fmul_pipe.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fmul_pipe (
	input logic clk,
	input logic reset,
	dispatch_if.sink disp,
	cdb_if.producer cdb
);
	logic [`FPU_MUL_STAGES-1:0] stage_valid;
	logic stall;
	logic take;

	logic s1_sign;
	logic signed [10:0] s1_exp;
	logic s1_zero;
	logic [23:0] s1_ma;
	logic [23:0] s1_mb;
	logic [`FPU_TAG_WIDTH-1:0] s1_tag;

	logic s2_sign;
	logic signed [10:0] s2_exp;
	logic s2_zero;
	logic [47:0] s2_prod;
	logic [`FPU_TAG_WIDTH-1:0] s2_tag;

	fpu_data_pkg::word_t s3_data;
	logic [`FPU_TAG_WIDTH-1:0] s3_tag;

	logic [22:0] norm_mant;
	logic guard;
	logic sticky;
	logic signed [10:0] norm_exp;
	logic round_up;
	logic [23:0] rnd_mant;
	logic signed [10:0] fin_exp;
	fpu_data_pkg::word_t result;

	// An unaccepted result in the last stage freezes everything behind it.
	assign stall = stage_valid[`FPU_MUL_STAGES-1] && !cdb.ready;
	assign disp.ready = !stall;
	assign take = disp.valid && disp.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= '0;
		end else if (!stall) begin
			stage_valid <= {stage_valid[`FPU_MUL_STAGES-2:0], take};
		end
	end

	// Product mantissa lies in [1, 4), so at most one right shift is needed.
	always_comb begin
		if (s2_prod[47]) begin
			norm_mant = s2_prod[46:24];
			guard = s2_prod[23];
			sticky = |s2_prod[22:0];
			norm_exp = s2_exp + 11'sd1;
		end else begin
			norm_mant = s2_prod[45:23];
			guard = s2_prod[22];
			sticky = |s2_prod[21:0];
			norm_exp = s2_exp;
		end
		round_up = guard && (sticky || norm_mant[0]);  // Ties go to the even mantissa.
		rnd_mant = {1'b0, norm_mant} + 24'(round_up);
		fin_exp = rnd_mant[23] ? norm_exp + 11'sd1 : norm_exp;
		if (s2_zero || fin_exp <= 0) begin
			result = {s2_sign, 31'd0};
		end else if (fin_exp >= 255) begin
			result = {s2_sign, 8'hfe, 23'h7fffff};  // Largest finite magnitude.
		end else begin
			result = {s2_sign, fin_exp[7:0], rnd_mant[22:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s1_sign <= disp.a[31] ^ disp.b[31] ^ (disp.op == fpu_issue_pkg::op_fnmul);
			s1_exp <= $signed({3'b000, disp.a[30:23]}) + $signed({3'b000, disp.b[30:23]}) -
			          11'sd127;
			s1_zero <= disp.a[30:23] == 8'd0 || disp.b[30:23] == 8'd0;  // Subnormals count as zero.
			s1_ma <= {1'b1, disp.a[22:0]};
			s1_mb <= {1'b1, disp.b[22:0]};
			s1_tag <= disp.tag;

			s2_sign <= s1_sign;
			s2_exp <= s1_exp;
			s2_zero <= s1_zero;
			s2_prod <= s1_ma * s1_mb;
			s2_tag <= s1_tag;

			s3_data <= result;
			s3_tag <= s2_tag;
		end
	end

	assign cdb.valid = stage_valid[`FPU_MUL_STAGES-1];
	assign cdb.tag = s3_tag;
	assign cdb.data = s3_data;
endmodule

// ==== rtl/fmul_station.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fmul_station (
	input logic clk,
	input logic reset,
	input logic rs_valid,
	output logic rs_ready,
	input fpu_issue_pkg::issue_op_t rs_op,
	cdb_if.listener cdb,
	dispatch_if.source disp
);
	localparam int SEL_W = $clog2(`FPU_RS_ENTRIES);

	fpu_issue_pkg::rs_entry_t e [`FPU_RS_ENTRIES];  // Packed from index 0, oldest first.
	fpu_issue_pkg::rs_entry_t e_upd [`FPU_RS_ENTRIES];
	fpu_issue_pkg::rs_entry_t e_next [`FPU_RS_ENTRIES];
	fpu_issue_pkg::rs_entry_t e_in;
	fpu_data_pkg::cdb_t res;
	logic [`FPU_RS_ENTRIES-1:0] ready;
	logic [SEL_W-1:0] sel;
	logic dispatch;
	logic write;

	function automatic fpu_data_pkg::operand_t capture(
		input fpu_data_pkg::operand_t o,
		input fpu_data_pkg::cdb_t r
	);
		fpu_data_pkg::operand_t c;
		c = o;
		if (!o.valid && r.valid && o.tag == r.tag) begin
			c.valid = 1'b1;
			c.data = r.data;
		end
		return c;
	endfunction

	assign res.valid = cdb.fire;
	assign res.tag = cdb.tag;
	assign res.data = cdb.data;

	assign e_in.valid = 1'b1;
	assign e_in.op = rs_op.op;
	assign e_in.tag = rs_op.tag;
	assign e_in.a = capture(rs_op.a, res);
	assign e_in.b = capture(rs_op.b, res);

	always_comb begin
		for (int i = 0; i < `FPU_RS_ENTRIES; i++) begin
			e_upd[i] = e[i];
			e_upd[i].a = capture(e[i].a, res);
			e_upd[i].b = capture(e[i].b, res);
			ready[i] = e[i].valid && e[i].a.valid && e[i].b.valid;
		end
	end

	// Lowest index wins, which is also the oldest entry.
	always_comb begin
		sel = '0;
		for (int i = `FPU_RS_ENTRIES - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel = SEL_W'(i);
			end
		end
	end

	assign disp.valid = |ready;
	assign disp.op = e[sel].op;
	assign disp.tag = e[sel].tag;
	assign disp.a = e[sel].a.data;
	assign disp.b = e[sel].b.data;

	assign dispatch = disp.valid && disp.ready;
	assign rs_ready = !e[`FPU_RS_ENTRIES-1].valid || dispatch;
	assign write = rs_valid && rs_ready;

	// Survivors slide down over the dispatched slot and the new entry goes behind them.
	always_comb begin
		int n;
		n = 0;
		for (int i = 0; i < `FPU_RS_ENTRIES; i++) begin
			e_next[i] = e_upd[i];
			e_next[i].valid = 1'b0;
		end
		for (int i = 0; i < `FPU_RS_ENTRIES; i++) begin
			if (e_upd[i].valid && !(dispatch && sel == SEL_W'(i))) begin
				e_next[n] = e_upd[i];
				n++;
			end
		end
		if (write) begin
			e_next[n] = e_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FPU_RS_ENTRIES; i++) begin
				e[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `FPU_RS_ENTRIES; i++) begin
				e[i] <= e_next[i];
			end
		end
	end
endmodule

// ==== rtl/fpr_rename.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpr_rename (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input fpu_issue_pkg::opcode_e issue_op,
	input logic [`FPU_REG_WIDTH-1:0] issue_rd,
	input logic [`FPU_REG_WIDTH-1:0] issue_rs1,
	input logic [`FPU_REG_WIDTH-1:0] issue_rs2,
	input fpu_data_pkg::word_t issue_imm,
	output logic [`FPU_TAG_WIDTH-1:0] issue_tag,
	output logic rs_valid,
	input logic rs_ready,
	output fpu_issue_pkg::issue_op_t rs_op,
	cdb_if.listener cdb,
	input logic [`FPU_REG_WIDTH-1:0] reg_addr,
	output fpu_data_pkg::word_t reg_data,
	output logic reg_busy
);
	fpu_data_pkg::word_t fpr_val [`FPU_NUM_FPR];
	logic [`FPU_NUM_FPR-1:0] fpr_busy;
	logic [`FPU_TAG_WIDTH-1:0] fpr_tag [`FPU_NUM_FPR];
	logic [(1 << `FPU_TAG_WIDTH)-1:0] tag_busy;
	logic [`FPU_TAG_WIDTH-1:0] next_tag;
	logic [`FPU_TAG_WIDTH:0] inflight;
	logic out_of_reset;
	logic tag_free;
	logic accept;
	logic mul_accept;
	logic [`FPU_REG_WIDTH-1:0] src_addr [2];
	fpu_data_pkg::operand_t src [2];

	assign tag_free = !tag_busy[next_tag];
	assign issue_ready = out_of_reset && (inflight < (1 << `FPU_TAG_WIDTH)) && rs_ready &&
	                     (issue_op == fpu_issue_pkg::op_li || tag_free);
	assign accept = issue_valid && issue_ready;
	assign mul_accept = accept && issue_op != fpu_issue_pkg::op_li;
	assign issue_tag = next_tag;

	assign src_addr[0] = issue_rs1;
	assign src_addr[1] = issue_rs2;

	// A result firing this cycle is forwarded straight into the new instruction.
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			src[i].tag = fpr_tag[src_addr[i]];
			if (!fpr_busy[src_addr[i]]) begin
				src[i].valid = 1'b1;
				src[i].data = fpr_val[src_addr[i]];
			end else if (cdb.fire && cdb.tag == fpr_tag[src_addr[i]]) begin
				src[i].valid = 1'b1;
				src[i].data = cdb.data;
			end else begin
				src[i].valid = 1'b0;
				src[i].data = '0;
			end
		end
	end

	assign rs_valid = mul_accept;
	assign rs_op.op = issue_op;
	assign rs_op.tag = next_tag;
	assign rs_op.a = src[0];
	assign rs_op.b = src[1];

	assign reg_data = fpr_val[reg_addr];
	assign reg_busy = fpr_busy[reg_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			out_of_reset <= 1'b0;
			fpr_busy <= '0;
			tag_busy <= '0;
			next_tag <= '0;
			inflight <= '0;
			for (int i = 0; i < `FPU_NUM_FPR; i++) begin
				fpr_val[i] <= '0;
				fpr_tag[i] <= '0;
			end
		end else begin
			out_of_reset <= 1'b1;
			for (int i = 0; i < `FPU_NUM_FPR; i++) begin
				if (cdb.fire && fpr_busy[i] && fpr_tag[i] == cdb.tag) begin
					fpr_val[i] <= cdb.data;  // A retagged register no longer matches.
					fpr_busy[i] <= 1'b0;
				end
			end
			if (cdb.fire) begin
				tag_busy[cdb.tag] <= 1'b0;
			end
			if (accept && issue_op == fpu_issue_pkg::op_li) begin
				fpr_val[issue_rd] <= issue_imm;
				fpr_busy[issue_rd] <= 1'b0;
			end
			if (mul_accept) begin
				fpr_busy[issue_rd] <= 1'b1;
				fpr_tag[issue_rd] <= next_tag;
				tag_busy[next_tag] <= 1'b1;
				next_tag <= next_tag + 1'b1;  // Wraps after the last tag.
			end
			case ({mul_accept, cdb.fire})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end
endmodule

// ==== common/dispatch_if.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

interface dispatch_if;
	logic valid;
	logic ready;
	fpu_issue_pkg::opcode_e op;
	logic [`FPU_TAG_WIDTH-1:0] tag;
	fpu_data_pkg::word_t a;
	fpu_data_pkg::word_t b;

	modport source (
		output valid, op, tag, a, b,
		input ready
	);

	modport sink (
		input valid, op, tag, a, b,
		output ready
	);
endinterface

// ==== common/cdb_if.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

interface cdb_if;
	logic valid;
	logic ready;
	logic [`FPU_TAG_WIDTH-1:0] tag;
	fpu_data_pkg::word_t data;
	logic fire;

	assign fire = valid && ready;  // A broadcast counts only once it is accepted.

	modport producer (
		output valid, tag, data,
		input ready
	);

	modport listener (
		input valid, tag, data, fire
	);
endinterface

// ==== common/fpu_issue_pkg.sv ====
`include "fpu_consts.svh"

package fpu_issue_pkg;

	typedef enum logic [1:0] {
		op_li = 2'd0,
		op_fmul = 2'd1,
		op_fnmul = 2'd2
	} opcode_e;

	// Instruction after renaming, as it enters the station.
	typedef struct packed {
		opcode_e op;
		logic [`FPU_TAG_WIDTH-1:0] tag;
		fpu_data_pkg::operand_t a;
		fpu_data_pkg::operand_t b;
	} issue_op_t;

	typedef struct packed {
		logic valid;
		opcode_e op;
		logic [`FPU_TAG_WIDTH-1:0] tag;
		fpu_data_pkg::operand_t a;
		fpu_data_pkg::operand_t b;
	} rs_entry_t;

endpackage

// ==== common/fpu_data_pkg.sv ====
`include "fpu_consts.svh"

package fpu_data_pkg;

	typedef logic [`FPU_WORD-1:0] word_t;  // IEEE 754 single precision.

	// One broadcast result, or a pending value named by its producer tag.
	typedef struct packed {
		logic valid;
		logic [`FPU_TAG_WIDTH-1:0] tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		logic valid;  // Data holds the value when set.
		logic [`FPU_TAG_WIDTH-1:0] tag;  // Producer of the value while not valid.
		word_t data;
	} operand_t;

endpackage

// ==== common/fpu_consts.svh ====
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Result tags, eight of them in round-robin use.
`define FPU_TAG_WIDTH 3

`define FPU_NUM_FPR 8
`define FPU_REG_WIDTH 3

`define FPU_RS_ENTRIES 2

`define FPU_MUL_STAGES 3

`define FPU_WORD 32

`endif
